/* hdl/key_stream_source.sv */
// Key driven counting source

module key_stream_source
    import stream_merge_pkg::*;
# (
    parameter logic tag = 1'b0
)
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    key,
    input  logic    ready,
    output stream_t stream
);

    logic                key_meta;
    logic                key_sync;
    logic [item_w - 2:0] count;

    // Two flop synchronizer, the second flop is the valid
    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_meta <= 1'b0;
            key_sync <= 1'b0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    always_ff @ (posedge clk or negedge arst_n)
        if (!arst_n)
            count <= '0;
        else if (key_sync & ready)
            count <= count + 1'b1;  // Wraps 7 to 0

    assign stream.valid      = key_sync;
    assign stream.item.tag   = tag;
    assign stream.item.value = count;

endmodule

/* hdl/rr_fifo_arbiter.sv */
// Round-robin merge of two FIFOs

module rr_fifo_arbiter
    import stream_merge_pkg::*;
# (
    parameter int depth = 4
)
(
    input  logic    clk,
    input  logic    arst_n,
    input  stream_t a_stream,
    output logic    a_ready,
    input  stream_t b_stream,
    output logic    b_ready,
    output stream_t out_stream,
    input  logic    hold
);

    stream_t a_head;
    stream_t b_head;
    logic    a_head_ready;
    logic    b_head_ready;
    logic    out_ready;
    logic    grant_b;
    logic    last_b;    // B won the last transfer
    logic    locked;    // An offer is waiting under back-pressure
    logic    locked_b;  // Grant of that waiting offer

    stream_fifo # (.depth (depth)) a_fifo_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_stream  (a_stream),
        .in_ready   (a_ready),
        .out_stream (a_head),
        .out_ready  (a_head_ready)
    );

    stream_fifo # (.depth (depth)) b_fifo_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_stream  (b_stream),
        .in_ready   (b_ready),
        .out_stream (b_head),
        .out_ready  (b_head_ready)
    );

    assign out_ready = ~hold;

    // --------------------
    // Grant choice

    always_comb
        if (locked)
            grant_b = locked_b;  // Keep the offered item stable
        else if (a_head.valid & b_head.valid)
            grant_b = ~last_b;
        else
            grant_b = b_head.valid;

    assign out_stream   = grant_b ? b_head : a_head;
    assign a_head_ready = out_ready & ~grant_b;
    assign b_head_ready = out_ready &  grant_b;

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            last_b   <= 1'b1;  // So A goes first
            locked   <= 1'b0;
            locked_b <= 1'b0;
        end
        else
        begin
            locked   <= out_stream.valid & ~out_ready;
            locked_b <= grant_b;

            if (out_stream.valid & out_ready)
                last_b <= grant_b;
        end
    end

endmodule

/* hdl/seven_segment_display.sv */
// Multiplexed hex display scanner

module seven_segment_display
# (
    parameter int w_digit  = 8,
                  scan_div = 4
)
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [w_digit * 4 - 1:0] number,
    output logic [              7:0] abcdefgh,
    output logic [w_digit     - 1:0] digit
);

    localparam int div_w = scan_div > 1 ? $clog2(scan_div) : 1;
    localparam int pos_w = w_digit  > 1 ? $clog2(w_digit)  : 1;

    logic [div_w - 1:0] div_cnt;
    logic [pos_w - 1:0] pos;     // Index of the lit digit
    logic               step;
    logic [        3:0] nibble;

    assign step = div_cnt == div_w'(scan_div - 1);

    // --------------------
    // Scan divider and digit rotation

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            pos     <= '0;
            digit   <= w_digit'(1);
        end
        else if (step)
        begin
            div_cnt <= '0;
            digit   <= (digit << 1) | (digit >> (w_digit - 1));
            pos     <= pos == pos_w'(w_digit - 1) ? '0 : pos + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign nibble = number [pos * 4 +: 4];

    // Hex to segments, dot always off
    always_comb
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;  // f
        endcase

endmodule

/* hdl/stream_fifo.sv */
// Valid/ready item FIFO

module stream_fifo
    import stream_merge_pkg::*;
# (
    parameter int depth = 4
)
(
    input  logic    clk,
    input  logic    arst_n,
    input  stream_t in_stream,
    output logic    in_ready,
    output stream_t out_stream,
    input  logic    out_ready
);

    localparam int ptr_w = depth > 1 ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    item_t              mem [0:depth - 1];
    logic [ptr_w - 1:0] wr_ptr;
    logic [ptr_w - 1:0] rd_ptr;
    logic [cnt_w - 1:0] count;
    logic               push;
    logic               pop;

    // Pointer step with wrap at depth
    function automatic logic [ptr_w - 1:0] next_ptr (input logic [ptr_w - 1:0] ptr);
        return ptr == ptr_w'(depth - 1) ? '0 : ptr + 1'b1;
    endfunction

    // --------------------
    // Flags from registered occupancy

    assign in_ready         = count != cnt_w'(depth);  // Not full
    assign out_stream.valid = count != '0;             // Not empty
    assign out_stream.item  = mem [rd_ptr];

    assign push = in_stream.valid  & in_ready;
    assign pop  = out_stream.valid & out_ready;

    // --------------------
    // Storage and pointers

    always_ff @ (posedge clk)
        if (push)
            mem [wr_ptr] <= in_stream.item;

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr (wr_ptr);

            if (pop)
                rd_ptr <= next_ptr (rd_ptr);

            // Simultaneous push and pop keeps the count
            if (push & ~pop)
                count <= count + 1'b1;
            else if (pop & ~push)
                count <= count - 1'b1;
        end
    end

endmodule

/* hdl/stream_merge_pkg.sv */
// Stream merge shared types

package stream_merge_pkg;

    localparam int item_w = 4;

    typedef struct packed
    {
        logic                tag;    // 0 for A, 1 for B
        logic [item_w - 2:0] value;
    } item_t;

    typedef struct packed
    {
        logic  valid;
        item_t item;
    } stream_t;

    typedef struct packed
    {
        logic a_ready;
        logic b_ready;
        logic out_ready;
    } ready_status_t;

    // Status digit segments in abcdefgh order
    localparam logic [7:0] sign_ready_a   = 8'b1000_0000,  // Top bar
                           sign_ready_b   = 8'b0000_0010,  // Middle bar
                           sign_ready_out = 8'b0001_0000,  // Bottom bar
                           sign_nothing   = 8'b0000_0000;

endpackage

/* hdl/stream_merge_top.sv */
// Two-source stream merger top

module stream_merge_top
    import stream_merge_pkg::*;
# (
    parameter int depth    = 4,
                  w_digit  = 8,
                  scan_div = 4
)
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 a_key,
    input  logic                 b_key,
    input  logic                 hold,
    output stream_t              out_stream,
    output logic                 a_ready,
    output logic                 b_ready,
    output logic [          7:0] abcdefgh,
    output logic [w_digit - 1:0] digit
);

    stream_t       a_stream;
    stream_t       b_stream;
    ready_status_t status;

    assign status = '{ a_ready: a_ready, b_ready: b_ready, out_ready: ~hold };

    // --------------------
    // Sources, A counts 0..7 and B counts 8..f

    key_stream_source # (.tag (1'b0)) a_source_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .key    (a_key),
        .ready  (a_ready),
        .stream (a_stream)
    );

    key_stream_source # (.tag (1'b1)) b_source_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .key    (b_key),
        .ready  (b_ready),
        .stream (b_stream)
    );

    rr_fifo_arbiter # (.depth (depth)) arbiter_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .a_stream   (a_stream),
        .a_ready    (a_ready),
        .b_stream   (b_stream),
        .b_ready    (b_ready),
        .out_stream (out_stream),
        .hold       (hold)
    );

    stream_status_display # (.w_digit (w_digit), .scan_div (scan_div)) status_display_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .a_item    (a_stream.item),
        .b_item    (b_stream.item),
        .out_item  (out_stream.item),
        .out_valid (out_stream.valid),
        .status    (status),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

endmodule

/* hdl/stream_status_display.sv */
// Stream values and ready status display

module stream_status_display
    import stream_merge_pkg::*;
# (
    parameter int w_digit  = 8,
                  scan_div = 4
)
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  item_t                a_item,
    input  item_t                b_item,
    input  item_t                out_item,
    input  logic                 out_valid,
    input  ready_status_t        status,
    output logic [          7:0] abcdefgh,
    output logic [w_digit - 1:0] digit
);

    localparam int w_number = w_digit * 4;

    logic [w_number - 1:0] number;
    logic [           7:0] abcdefgh_pre;
    logic [           7:0] ready_signs;

    // A, B, blank slot for status, then output
    assign number = w_number'({ a_item, b_item, {item_w {1'b0}}, out_item });

    seven_segment_display # (.w_digit (w_digit), .scan_div (scan_div)) display_i
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .number   (number),
        .abcdefgh (abcdefgh_pre),
        .digit    (digit)
    );

    always_comb
    begin
        ready_signs = sign_nothing;

        if (status.a_ready)
            ready_signs |= sign_ready_a;
        if (status.b_ready)
            ready_signs |= sign_ready_b;
        if (status.out_ready)
            ready_signs |= sign_ready_out;
    end

    // --------------------
    // Segment overlay per position

    always_comb
        case (digit)
            w_digit'(1): abcdefgh = out_valid ? abcdefgh_pre : sign_nothing;
            w_digit'(2): abcdefgh = ready_signs;
            w_digit'(4),
            w_digit'(8): abcdefgh = abcdefgh_pre;  // B and A inputs
            default:     abcdefgh = sign_nothing;
        endcase

endmodule

/* stream_merge_top.f */
hdl/stream_merge_pkg.sv
hdl/key_stream_source.sv
hdl/stream_fifo.sv
hdl/rr_fifo_arbiter.sv
hdl/seven_segment_display.sv
hdl/stream_status_display.sv
hdl/stream_merge_top.sv
testbench/tb_clock.sv
testbench/stream_merge_assert.sv
testbench/stream_merge_tb.sv

/* testbench/stream_merge_assert.sv */
// Arbiter handshake assertions

module stream_merge_assert
    import stream_merge_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    hold,
    input stream_t a_head,
    input stream_t b_head,
    input stream_t out_stream
);

    // Offered item holds while stalled
    property item_stable_under_hold;
        @ (posedge clk) disable iff (!arst_n)
            out_stream.valid && hold |=> $stable (out_stream.item);
    endproperty

    property valid_kept_until_transfer;
        @ (posedge clk) disable iff (!arst_n)
            out_stream.valid && hold |=> out_stream.valid;
    endproperty

    // --------------------
    // Back to back transfers with both heads waiting switch source

    property grants_alternate;
        @ (posedge clk) disable iff (!arst_n)
            (out_stream.valid && !hold) ##1 (a_head.valid && b_head.valid)
                |-> out_stream.item.tag != $past (out_stream.item.tag);
    endproperty

    assert property (item_stable_under_hold)
        else $error ("Output item changed while held");

    assert property (valid_kept_until_transfer)
        else $error ("Output valid dropped without a transfer");

    assert property (grants_alternate)
        else $error ("Grant did not alternate with both heads valid");

endmodule

bind rr_fifo_arbiter stream_merge_assert arbiter_assert_i
(
    .clk        (clk),
    .arst_n     (arst_n),
    .hold       (hold),
    .a_head     (a_head),
    .b_head     (b_head),
    .out_stream (out_stream)
);

/* testbench/stream_merge_tb.sv */
// Stream merge testbench

module stream_merge_tb
    import stream_merge_pkg::*;
();

    localparam int depth    = 4;
    localparam int w_digit  = 8;
    localparam int scan_div = 4;

    logic                 clk;
    logic                 arst_n;
    logic                 a_key;
    logic                 b_key;
    logic                 hold;
    stream_t              out_stream;
    logic                 a_ready;
    logic                 b_ready;
    logic [          7:0] abcdefgh;
    logic [w_digit - 1:0] digit;

    // Reference model state
    item_t                a_q [$];
    item_t                b_q [$];
    item_t                out_log [$];
    logic [item_w  - 2:0] a_cnt;
    logic [item_w  - 2:0] b_cnt;
    logic                 a_meta;  // Key synchronizer copies
    logic                 a_sync;
    logic                 b_meta;
    logic                 b_sync;
    int                   a_accepts;
    int                   b_accepts;
    logic [w_digit - 1:0] exp_digit;
    int                   scan_cnt;

    int item_errors;
    int seg_errors;
    int flag_errors;
    int digit_errors;
    int other_errors;

    tb_clock # (.period (100)) clock_i (.clk (clk));

    stream_merge_top # (.depth (depth), .w_digit (w_digit), .scan_div (scan_div)) dut_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .a_key      (a_key),
        .b_key      (b_key),
        .hold       (hold),
        .out_stream (out_stream),
        .a_ready    (a_ready),
        .b_ready    (b_ready),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

    // --------------------
    // Compare tasks

    task automatic check_item (input item_t got, input item_t exp, input string what);
        if (got !== exp)
        begin
            item_errors++;
            $display ("** Error at %0t: %s item %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_segments (input logic [7:0] got, input logic [7:0] exp,
                                   input string what);
        if (got !== exp)
        begin
            seg_errors++;
            $display ("** Error at %0t: %s segments %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag (input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            flag_errors++;
            $display ("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_digit (input logic [w_digit - 1:0] got,
                                input logic [w_digit - 1:0] exp, input string what);
        if (got !== exp)
        begin
            digit_errors++;
            $display ("** Error at %0t: %s %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One bar per ready signal
    function automatic logic [7:0] status_signs (input logic a_rdy, b_rdy, out_rdy);
        logic [7:0] signs;
        signs = sign_nothing;
        if (a_rdy)
            signs = signs | sign_ready_a;
        if (b_rdy)
            signs = signs | sign_ready_b;
        if (out_rdy)
            signs = signs | sign_ready_out;
        return signs;
    endfunction

    // --------------------
    // Monitor and model on pre-edge values

    always @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_q.delete ();
            b_q.delete ();
            {a_cnt, b_cnt, a_meta, a_sync, b_meta, b_sync} = '0;
            a_accepts = 0;
            b_accepts = 0;
            exp_digit = w_digit'(1);
            scan_cnt  = 0;
        end
        else
        begin
            if (out_stream.valid && !hold)
            begin
                out_log.push_back (out_stream.item);
                if (out_stream.item.tag ? b_q.size () == 0 : a_q.size () == 0)
                begin
                    other_errors++;
                    $display ("Output item %h at %0t has no pending source item",
                              out_stream.item, $time);
                end
                else if (out_stream.item.tag)
                    check_item (out_stream.item, b_q.pop_front (), "B output");
                else
                    check_item (out_stream.item, a_q.pop_front (), "A output");
            end

            if (a_sync && a_ready)
            begin
                a_q.push_back (item_t'{tag: 1'b0, value: a_cnt});
                a_cnt++;      // Wraps like a 3-bit counter
                a_accepts++;
            end
            if (b_sync && b_ready)
            begin
                b_q.push_back (item_t'{tag: 1'b1, value: b_cnt});
                b_cnt++;
                b_accepts++;
            end

            a_sync = a_meta;
            a_meta = a_key;
            b_sync = b_meta;
            b_meta = b_key;

            // One position per scan period
            check_digit (digit, exp_digit, "Digit select");
            if (scan_cnt == scan_div - 1)
            begin
                scan_cnt  = 0;
                exp_digit = {exp_digit [w_digit - 2:0], exp_digit [w_digit - 1]};
            end
            else
                scan_cnt++;

            if (digit == w_digit'(2))
                check_segments (abcdefgh, status_signs (a_ready, b_ready, !hold), "Status");
            if (digit == w_digit'(1) && !out_stream.valid)
                check_segments (abcdefgh, sign_nothing, "Idle output digit");
        end
    end

    // --------------------
    // Sequencing helpers

    task automatic apply_reset ();
        arst_n = 1'b0;
        repeat (2) @ (posedge clk);
        @ (negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic wait_drained (input int limit);
        int n;
        for (n = 0; n < limit; n++)
        begin
            @ (negedge clk);
            if (a_q.size () == 0 && b_q.size () == 0 && !a_meta && !b_meta
                && !a_sync && !b_sync && !out_stream.valid)
                break;
        end
        if (n == limit)
        begin
            other_errors++;
            $display ("Timeout at %0t: FIFOs did not drain", $time);
        end
    endtask

    task automatic wait_both_full (input int limit);
        int n;
        for (n = 0; n < limit; n++)
        begin
            @ (negedge clk);
            if (!a_ready && !b_ready)
                break;
        end
        if (n == limit)
        begin
            other_errors++;
            $display ("Timeout at %0t: readies never went low under hold", $time);
        end
    endtask

    task automatic wait_keys_idle (input int limit);
        int n;
        for (n = 0; n < limit; n++)
        begin
            @ (negedge clk);
            if (!a_meta && !b_meta && !a_sync && !b_sync)
                break;
        end
        if (n == limit)
        begin
            other_errors++;
            $display ("Timeout at %0t: source valids stayed high", $time);
        end
    endtask

    initial
    begin
        void'($urandom (35));
        {item_errors, seg_errors, flag_errors, digit_errors, other_errors} = '0;
        a_key  = 1'b0;
        b_key  = 1'b0;
        hold   = 1'b0;
        arst_n = 1'b0;

        apply_reset ();
        check_flag (out_stream.valid, 1'b0, "Output valid after reset");
        check_flag (a_ready, 1'b1, "A ready after reset");
        check_flag (b_ready, 1'b1, "B ready after reset");

        // Random keys and back-pressure
        for (int i = 0; i < 800; i++)
        begin
            @ (negedge clk);
            if ($urandom % 4 == 0)
                a_key = ~a_key;
            if ($urandom % 4 == 0)
                b_key = ~b_key;
            hold = $urandom % 3 == 0;
        end
        a_key = 1'b0;
        b_key = 1'b0;
        hold  = 1'b0;
        wait_drained (100);

        // --------------------
        // Fill both FIFOs under hold from a fresh grant pointer

        apply_reset ();
        hold  = 1'b1;
        a_key = 1'b1;
        b_key = 1'b1;
        wait_both_full (100);
        a_key = 1'b0;
        b_key = 1'b0;
        wait_keys_idle (20);
        if (a_accepts != depth || b_accepts != depth)
        begin
            other_errors++;
            $display ("** Error at %0t: accepted A %0d, B %0d under hold, expected %0d each",
                      $time, a_accepts, b_accepts, depth);
        end

        // Drain should alternate starting with A
        out_log.delete ();
        hold = 1'b0;
        wait_drained (100);
        if (out_log.size () != 2 * depth)
        begin
            other_errors++;
            $display ("Drain delivered %0d items instead of %0d", out_log.size (), 2 * depth);
        end
        foreach (out_log [i])
            check_flag (out_log [i].tag, 1'(i % 2), "Drain tag");

        $display ("Errors: items %0d, segments %0d, flags %0d, digits %0d, other %0d",
                  item_errors, seg_errors, flag_errors, digit_errors, other_errors);
        if (item_errors + seg_errors + flag_errors + digit_errors + other_errors == 0)
            $display ("TEST OK");
        else
            $display ("TEST FAILED");
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
// Testbench clock source

module tb_clock
# (
    parameter int period = 100
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    always
        #(period / 2) clk = ~clk;

endmodule
